// ==== l2_front_defines.svh ====
/*
 * L2 request front end configuration
 * Core count and the address and line widths shared by every block
 */

`ifndef L2_FRONT_DEFINES_SVH
`define L2_FRONT_DEFINES_SVH

// Number of cores that present requests
`define NUM_CORES 4

// Cache-line address width
`define ADDR_BITS 26

// One cache line of data
`define LINE_BITS 128

`endif

// ==== l2_front_pkg.sv ====
/*
 * L2 front end types
 * Request packets, line data and the restart bundle that the
 * bus interface sends back after a miss
 */

`default_nettype none

`include "l2_front_defines.svh"

package l2_front_pkg;

	// Index of a requesting core
	typedef logic [$clog2(`NUM_CORES) - 1:0] core_id_t;

	// Request kinds a core can issue
	typedef enum logic [2:0]
	{
		L2REQ_LOAD,
		L2REQ_STORE,
		L2REQ_FLUSH,
		L2REQ_IINVALIDATE,
		L2REQ_DINVALIDATE
	} l2req_type_t;

	// One full line of data
	typedef logic [`LINE_BITS - 1:0] cache_line_data_t;

	// Request packet as seen by the tag stage
	typedef struct packed
	{
		logic valid;
		l2req_type_t packet_type;
		core_id_t core;
		logic [3:0] id;                  // Transaction tag
		logic [`ADDR_BITS - 1:0] address;
		cache_line_data_t store_data;
	} l2req_packet_t;

	// Restarted request with its fill data from memory
	typedef struct packed
	{
		l2req_packet_t request;
		cache_line_data_t data;
		logic collided_miss;             // Another miss already filled this line
	} l2_restart_t;

endpackage

`default_nettype wire

// ==== rr_arbiter.sv ====
/*
 * Round-robin arbiter
 * Grants the first active requester after the last winner and
 * encodes the one-hot grant as a core index
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_front_defines.svh"

module rr_arbiter
	import l2_front_pkg::*;
	#(parameter NUM_REQUESTERS = `NUM_CORES)
	(
	input wire logic clk,
	input wire logic reset,
	input wire logic [NUM_REQUESTERS - 1:0] request,
	input wire logic advance,
	output logic [NUM_REQUESTERS - 1:0] grant_oh,
	output core_id_t grant_idx
	);

	// Index of the most recent winner
	core_id_t last_grant;

	// Search the ring starting just past the last winner
	always_comb
	begin
		int unsigned cand;
		logic found;

		grant_oh = '0;
		found = 1'b0;
		for (int off = 1; off <= NUM_REQUESTERS; off++)
		begin
			cand = (int'(last_grant) + off) % NUM_REQUESTERS;
			if (!found && request[cand])
			begin
				grant_oh[cand] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// One-hot to index, at most one bit is set
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < NUM_REQUESTERS; i++)
		begin
			if (grant_oh[i])
				grant_idx = grant_idx | core_id_t'(i);
		end
	end

	// Pointer starts at the last requester so requester 0 wins first
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= core_id_t'(NUM_REQUESTERS - 1);
		else if (advance && |grant_oh)
			last_grant <= grant_idx;
	end

endmodule

`default_nettype wire

// ==== restart_slot.sv ====
/*
 * Restart holding slot
 * Keeps one restarted request and its line data from the bus
 * interface until the arbitration stage takes it
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_front_defines.svh"

module restart_slot
	import l2_front_pkg::*;
	(
	input wire logic clk,
	input wire logic reset,

	// From bus interface, single-cycle strobe
	input wire logic restart_strobe,
	input wire l2_restart_t restart,

	// To and from arbitration stage
	input wire logic take,
	output logic pending,
	output l2_restart_t pending_restart
	);

	// Occupancy flag
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pending <= 1'b0;
		else if (restart_strobe)
		begin
			// New strobe wins over a take in the same cycle
			pending <= 1'b1;
		end
		else if (take)
			pending <= 1'b0;
	end

	// Held restart, loaded only on the strobe
	always_ff @(posedge clk)
	begin
		if (restart_strobe)
			pending_restart <= restart;
	end

endmodule

`default_nettype wire

// ==== l2_cache_arb.sv ====
/*
 * L2 request arbitration stage
 * Chooses between a pending restart and the granted core request,
 * drives core ready and registers the packet for the tag stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_front_defines.svh"

module l2_cache_arb
	import l2_front_pkg::*;
	(
	input wire logic clk,
	input wire logic reset,

	// Cores
	input wire l2req_packet_t core_request[`NUM_CORES],
	output logic core_ready[`NUM_CORES],

	// Bus interface
	input wire logic bus_stall,

	// Restart slot
	input wire logic pending,
	input wire l2_restart_t pending_restart,
	output logic take,

	// Arbiter
	output logic [`NUM_CORES - 1:0] request,
	output logic advance,
	input wire logic [`NUM_CORES - 1:0] grant_oh,
	input wire core_id_t grant_idx,

	// Tag stage
	output l2req_packet_t l2a_request,
	output cache_line_data_t l2a_data_from_memory,
	output logic l2a_is_l2_fill,
	output logic l2a_is_restarted_flush
	);

	logic can_accept;
	logic is_restarted_flush;
	l2req_packet_t grant_request;

	// Cores wait while a restart is held or the bus is stalled
	assign can_accept = !pending && !bus_stall;
	assign advance = can_accept;

	// A held restart always leaves on the next edge
	assign take = pending;

	assign is_restarted_flush = pending_restart.request.packet_type == L2REQ_FLUSH;

	// Valid bits feed the arbiter, ready comes back from the grant
	always_comb
	begin
		for (int i = 0; i < `NUM_CORES; i++)
		begin
			request[i] = core_request[i].valid;
			core_ready[i] = grant_oh[i] && can_accept;
		end
	end

	assign grant_request = core_request[grant_idx];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			l2a_request <= '0;
			l2a_data_from_memory <= '0;
			l2a_is_l2_fill <= 1'b0;
			l2a_is_restarted_flush <= 1'b0;
		end
		else if (pending)
		begin
			// Restarted request comes first
			l2a_request <= pending_restart.request;
			l2a_request.valid <= 1'b1;
			l2a_data_from_memory <= pending_restart.data;
			// Collided miss means the line is already there
			l2a_is_l2_fill <= !pending_restart.collided_miss && !is_restarted_flush;
			l2a_is_restarted_flush <= is_restarted_flush;
		end
		else if (|grant_oh && can_accept)
		begin
			// New core request
			l2a_request <= grant_request;
			l2a_data_from_memory <= '0;
			l2a_is_l2_fill <= 1'b0;
			l2a_is_restarted_flush <= 1'b0;
		end
		else
		begin
			// Bubble, payload fields keep their last value
			l2a_request.valid <= 1'b0;
			l2a_is_l2_fill <= 1'b0;
			l2a_is_restarted_flush <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== l2_front.sv ====
/*
 * L2 cache request front end
 * Restart slot, round-robin core arbiter and the arbitration stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_front_defines.svh"

module l2_front
	import l2_front_pkg::*;
	(
	input wire logic clk,
	input wire logic reset,

	// Cores
	input wire l2req_packet_t core_request[`NUM_CORES],
	output logic core_ready[`NUM_CORES],

	// Bus interface
	input wire logic restart_strobe,
	input wire l2_restart_t restart,
	input wire logic bus_stall,

	// Tag stage
	output l2req_packet_t l2a_request,
	output cache_line_data_t l2a_data_from_memory,
	output logic l2a_is_l2_fill,
	output logic l2a_is_restarted_flush
	);

	logic pending;
	logic take;
	l2_restart_t pending_restart;
	logic [`NUM_CORES - 1:0] request;
	logic [`NUM_CORES - 1:0] grant_oh;
	logic advance;
	core_id_t grant_idx;

	restart_slot restart_slot0(
		.clk(clk),
		.reset(reset),
		.restart_strobe(restart_strobe),
		.restart(restart),
		.take(take),
		.pending(pending),
		.pending_restart(pending_restart));

	rr_arbiter #(.NUM_REQUESTERS(`NUM_CORES)) rr_arbiter0(
		.clk(clk),
		.reset(reset),
		.request(request),
		.advance(advance),
		.grant_oh(grant_oh),
		.grant_idx(grant_idx));

	l2_cache_arb l2_cache_arb0(
		.clk(clk),
		.reset(reset),
		.core_request(core_request),
		.core_ready(core_ready),
		.bus_stall(bus_stall),
		.pending(pending),
		.pending_restart(pending_restart),
		.take(take),
		.request(request),
		.advance(advance),
		.grant_oh(grant_oh),
		.grant_idx(grant_idx),
		.l2a_request(l2a_request),
		.l2a_data_from_memory(l2a_data_from_memory),
		.l2a_is_l2_fill(l2a_is_l2_fill),
		.l2a_is_restarted_flush(l2a_is_restarted_flush));

endmodule

`default_nettype wire

// ==== tb_l2_front.sv ====
/*
 * Testbench for the L2 request front end
 * Table driven core and restart traffic, checked against a model of
 * the round-robin order, the restart slot and the output timing
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_front_defines.svh"

module tb_l2_front
	import l2_front_pkg::*;
	();

	// Table row whose expected columns give the output after this cycle
	typedef struct packed
	{
		logic [`NUM_CORES - 1:0] mask;
		l2req_type_t core_type;
		logic strobe;
		l2req_type_t restart_type;
		logic collided;
		logic stall;
		logic exp_valid;
		logic exp_fill;
		logic exp_flush;
	} step_t;

	logic clk;
	logic reset;
	l2req_packet_t core_request[`NUM_CORES];
	logic core_ready[`NUM_CORES];
	logic restart_strobe;
	l2_restart_t restart;
	logic bus_stall;
	l2req_packet_t l2a_request;
	cache_line_data_t l2a_data_from_memory;
	logic l2a_is_l2_fill;
	logic l2a_is_restarted_flush;

	step_t steps[$];
	logic [31:0] rng_state;
	logic [3:0] txn_id;
	int cycle_count;
	int cycle_limit;

	// Each core holds its packet until accepted
	l2req_packet_t core_pkt[`NUM_CORES];
	logic core_busy[`NUM_CORES];
	logic accepted[`NUM_CORES];
	int rr_ptr;

	// Bus interface and restart slot model
	logic model_pending;
	l2_restart_t held_restart;
	l2_restart_t next_restart;

	// Expected packet after the coming edge
	l2req_packet_t exp_pkt;
	cache_line_data_t exp_data;

	l2_front dut0(
		.clk(clk),
		.reset(reset),
		.core_request(core_request),
		.core_ready(core_ready),
		.restart_strobe(restart_strobe),
		.restart(restart),
		.bus_stall(bus_stall),
		.l2a_request(l2a_request),
		.l2a_data_from_memory(l2a_data_from_memory),
		.l2a_is_l2_fill(l2a_is_l2_fill),
		.l2a_is_restarted_flush(l2a_is_restarted_flush));

	always #20 clk = ~clk;

	// Run limit scales with the table length
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check_packet(input string name, input l2req_packet_t actual,
		input l2req_packet_t expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "packet compare failed");
		end
	endtask

	task automatic check_line(input string name, input cache_line_data_t actual,
		input cache_line_data_t expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "line compare failed");
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "flag compare failed");
		end
	endtask

	// Xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic cache_line_data_t random_line();
		cache_line_data_t line;

		for (int w = 0; w < `LINE_BITS / 32; w++)
			line[w * 32 +: 32] = next_rand();
		return line;
	endfunction

	function automatic l2req_packet_t make_core_packet(input int c, input l2req_type_t t);
		l2req_packet_t p;
		logic [31:0] rnd;

		rnd = next_rand();
		p.valid = 1'b1;
		p.packet_type = t;
		p.core = core_id_t'(c);
		p.id = txn_id;
		p.address = rnd[`ADDR_BITS - 1:0];
		// Loads carry no data
		p.store_data = (t == L2REQ_STORE) ? random_line() : '0;
		txn_id = txn_id + 4'd1;
		return p;
	endfunction

	function automatic l2_restart_t make_restart(input l2req_type_t t, input logic collided);
		l2_restart_t r;
		logic [31:0] rnd;

		rnd = next_rand();
		r.request.valid = 1'b1;
		r.request.packet_type = t;
		r.request.core = rnd[$bits(core_id_t) - 1:0];
		r.request.id = rnd[11:8];
		r.request.address = rnd[31:32 - `ADDR_BITS];
		r.request.store_data = '0;
		r.data = random_line();
		r.collided_miss = collided;
		return r;
	endfunction

	task automatic add_step(input logic [`NUM_CORES - 1:0] mask, input l2req_type_t ctype,
		input logic strobe, input l2req_type_t rtype, input logic collided, input logic stall,
		input logic ev, input logic ef, input logic efl);
		step_t s;

		s = '{mask, ctype, strobe, rtype, collided, stall, ev, ef, efl};
		steps.push_back(s);
	endtask

	// Row columns are core mask, core type, strobe, restart type, collided and stall
	// and then expected valid, fill and restarted flush
	task automatic build_table();
		// All four cores straight out of reset go round the ring from core 0
		for (int k = 0; k < 5; k++)
			add_step(4'b1111, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		// Stall holds everyone back and the order resumes afterwards
		add_step(4'b1111, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(4'b1111, L2REQ_STORE, 1'b0, L2REQ_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(4'b1111, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		for (int k = 0; k < 3; k++)
			add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		// Single loads on an idle front end
		add_step(4'b0001, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b1000, L2REQ_STORE, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		// Restarts on an idle front end with fill, collided miss and flush
		add_step(4'b0000, L2REQ_LOAD, 1'b1, L2REQ_LOAD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b1, L2REQ_LOAD, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b1, L2REQ_FLUSH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
		// Restart while cores request and then while the bus is stalled
		add_step(4'b1111, L2REQ_LOAD, 1'b1, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b1111, L2REQ_STORE, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
		add_step(4'b1111, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b1111, L2REQ_LOAD, 1'b1, L2REQ_FLUSH, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		add_step(4'b1111, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
		// Drain the held core requests
		for (int k = 0; k < 4; k++)
			add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_step(4'b0000, L2REQ_LOAD, 1'b0, L2REQ_LOAD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// Drive one row at the rising edge
	task automatic apply_step(input step_t s);
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			if (accepted[c])
				core_busy[c] = 1'b0;
			if (!core_busy[c] && s.mask[c])
			begin
				core_pkt[c] = make_core_packet(c, s.core_type);
				core_busy[c] = 1'b1;
			end
			core_request[c] <= core_busy[c] ? core_pkt[c] : '0;
			accepted[c] = 1'b0;
		end
		if (s.strobe)
		begin
			next_restart = make_restart(s.restart_type, s.collided);
			restart <= next_restart;
		end
		restart_strobe <= s.strobe;
		bus_stall <= s.stall;
	endtask

	// Reference arbitration on settled inputs ahead of the next edge
	task automatic predict(input step_t s);
		logic can_accept;
		logic exp_ready;
		int grant;
		int c;

		can_accept = !model_pending && !s.stall;
		grant = -1;
		for (int off = 1; off <= `NUM_CORES; off++)
		begin
			c = (rr_ptr + off) % `NUM_CORES;
			if (grant < 0 && core_busy[c])
				grant = c;
		end
		for (int k = 0; k < `NUM_CORES; k++)
		begin
			exp_ready = (k == grant) && can_accept;
			check_flag($sformatf("core_ready[%0d]", k), core_ready[k], exp_ready);
			accepted[k] = exp_ready;
		end
		if (model_pending)
		begin
			exp_pkt = held_restart.request;
			exp_data = held_restart.data;
		end
		else if (grant >= 0 && can_accept)
		begin
			exp_pkt = core_pkt[grant];
			exp_data = '0;
			rr_ptr = grant;
		end
		else
		begin
			exp_pkt = '0;
			exp_data = '0;
		end
		// Slot is loaded by the strobe and emptied one cycle later
		if (s.strobe)
			held_restart = next_restart;
		model_pending = s.strobe;
	endtask

	// Bubbles only promise low valid and flags
	task automatic check_outputs(input step_t s);
		check_flag("l2a_request.valid", l2a_request.valid, s.exp_valid);
		check_flag("l2a_is_l2_fill", l2a_is_l2_fill, s.exp_fill);
		check_flag("l2a_is_restarted_flush", l2a_is_restarted_flush, s.exp_flush);
		if (s.exp_valid)
		begin
			check_packet("l2a_request", l2a_request, exp_pkt);
			check_line("l2a_data_from_memory", l2a_data_from_memory, exp_data);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		restart_strobe = 1'b0;
		restart = '0;
		bus_stall = 1'b0;
		rng_state = 32'd42550;
		txn_id = 4'd0;
		rr_ptr = `NUM_CORES - 1;
		model_pending = 1'b0;
		held_restart = '0;
		next_restart = '0;
		exp_pkt = '0;
		exp_data = '0;
		cycle_count = 0;
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			core_request[c] = '0;
			core_pkt[c] = '0;
			core_busy[c] = 1'b0;
			accepted[c] = 1'b0;
		end
		build_table();
		cycle_limit = steps.size() * 8 + 100;

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// Outputs come out of reset cleared
		check_packet("l2a_request", l2a_request, '0);
		check_line("l2a_data_from_memory", l2a_data_from_memory, '0);
		check_flag("l2a_is_l2_fill", l2a_is_l2_fill, 1'b0);
		check_flag("l2a_is_restarted_flush", l2a_is_restarted_flush, 1'b0);

		for (int i = 0; i < steps.size(); i++)
		begin
			@(posedge clk);
			apply_step(steps[i]);
			@(negedge clk);
			if (i > 0)
				check_outputs(steps[i - 1]);
			predict(steps[i]);
		end
		@(posedge clk);
		restart_strobe <= 1'b0;
		bus_stall <= 1'b0;
		@(negedge clk);
		check_outputs(steps[steps.size() - 1]);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== l2_front.f ====
+incdir+.
l2_front_pkg.sv
rr_arbiter.sv
restart_slot.sv
l2_cache_arb.sv
l2_front.sv
tb_l2_front.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L2 front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_l2_front -f l2_front.f

out=$(./obj_dir/Vtb_l2_front) || true
echo "$out"

if echo "$out" | grep -qF ">>> PASS"; then
	exit 0
else
	exit 1
fi
